/* hdl/panel_pkg.sv */
`default_nettype none

package panel_pkg;

   localparam int PIXEL_W = 24;
   localparam int COLOR_W = PIXEL_W / 3;

   // Red sits in the high byte, blue in the low byte.
   typedef struct packed {
      logic [COLOR_W-1:0] red;
      logic [COLOR_W-1:0] green;
      logic [COLOR_W-1:0] blue;
   } pixel_t;

   // The sequencer counters step by this amount from one slice to the next.
   localparam int SLICE_STEP  = 32;
   localparam int SLICE_CNT_W = 8;

   // Driver chips take 9-bit channel words.
   localparam int CHANNEL_W = 9;

   localparam int DEF_NUM_BLOCKS  = 3;
   localparam int DEF_NUM_SLICES  = 7;
   localparam int DEF_RAM_DEPTH   = 16;
   localparam int DEF_LINE_PIXELS = 4;

endpackage

`default_nettype wire

/* hdl/pixel_wr_if.sv */
`default_nettype none

interface pixel_wr_if #(
   parameter int NUM_BLOCKS = panel_pkg::DEF_NUM_BLOCKS,
   parameter int RAM_DEPTH  = panel_pkg::DEF_RAM_DEPTH
);

   logic [$clog2(NUM_BLOCKS)-1:0] block;
   logic [$clog2(RAM_DEPTH)-1:0]  addr;
   panel_pkg::pixel_t             data;
   logic                          wen;

   modport source (output block, output addr, output data, output wen);
   modport sink   (input block, input addr, input data, input wen);

endinterface

`default_nettype wire

/* hdl/pixel_ram.sv */
`default_nettype none

module pixel_ram #(
   parameter int RAM_DEPTH = panel_pkg::DEF_RAM_DEPTH
) (
   input  wire                          clk,
   input  wire                          wen,
   input  wire [$clog2(RAM_DEPTH)-1:0]  waddr,
   input  wire panel_pkg::pixel_t       wdata,
   input  wire [$clog2(RAM_DEPTH)-1:0]  raddr,
   output panel_pkg::pixel_t            rdata
);

   panel_pkg::pixel_t mem [RAM_DEPTH];

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[waddr] <= wdata;
      end
   end

   // Read is registered and runs every clock, a write shows up one cycle later.
   always_ff @(posedge clk) begin
      rdata <= mem[raddr];
   end

endmodule

`default_nettype wire

/* hdl/line_framebuffer.sv */
`default_nettype none

module line_framebuffer #(
   parameter int RAM_DEPTH   = panel_pkg::DEF_RAM_DEPTH,
   parameter int LINE_PIXELS = panel_pkg::DEF_LINE_PIXELS
) (
   input  wire                                 clk,
   input  wire                                 nrst,
   input  wire                                 clk_enable,
   input  wire                                 sof,
   input  wire                                 eoc,
   output logic [$clog2(RAM_DEPTH)-1:0]        ram_addr,
   input  wire panel_pkg::pixel_t              ram_data,
   output panel_pkg::pixel_t [LINE_PIXELS-1:0] data_out,
   output logic                                driver_sof,
   output logic                                line_valid
);

   localparam int ADDR_W   = $clog2(RAM_DEPTH);
   localparam int LINES    = RAM_DEPTH / LINE_PIXELS;
   localparam int LINE_W   = $clog2(LINES);
   localparam int PIX_W    = $clog2(LINE_PIXELS);
   localparam int LAST_PIX = LINE_PIXELS - 1;

   logic [LINE_W-1:0] line_cnt;
   logic [PIX_W-1:0]  pix_cnt;
   logic [PIX_W-1:0]  cap_cnt;
   logic              rd_active;
   logic              cap_active;
   logic              en_d;
   logic              line_done;

   panel_pkg::pixel_t                   ram_hold;
   panel_pkg::pixel_t                   cap_pixel;
   panel_pkg::pixel_t [LINE_PIXELS-1:0] line_reg;
   panel_pkg::pixel_t [LINE_PIXELS-1:0] next_line;

   assign ram_addr = ADDR_W'(line_cnt * LINE_PIXELS + pix_cnt);

   // The RAM keeps reading while clk_enable is low, so the pixel returned
   // after the last enabled cycle is parked here until capture.
   always_ff @(posedge clk) begin
      if (en_d) begin
         ram_hold <= ram_data;
      end
   end

   assign cap_pixel = en_d ? ram_data : ram_hold;
   assign next_line = {cap_pixel, line_reg[LINE_PIXELS-1:1]};
   assign line_done = clk_enable && cap_active && (cap_cnt == PIX_W'(LAST_PIX));

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         en_d       <= 1'b0;
         driver_sof <= 1'b0;
         line_valid <= 1'b0;
         rd_active  <= 1'b0;
         cap_active <= 1'b0;
         pix_cnt    <= '0;
         cap_cnt    <= '0;
         line_cnt   <= '0;
      end else begin
         en_d       <= clk_enable;
         driver_sof <= clk_enable && sof;
         line_valid <= line_done;
         if (clk_enable) begin
            // Capture runs one enabled cycle behind the address.
            cap_active <= rd_active;
            cap_cnt    <= pix_cnt;
            if (rd_active) begin
               if (pix_cnt == PIX_W'(LAST_PIX)) begin
                  rd_active <= 1'b0;
                  pix_cnt   <= '0;
               end else begin
                  pix_cnt <= pix_cnt + 1'b1;
               end
            end else if (eoc && !cap_active) begin
               rd_active <= 1'b1;
               pix_cnt   <= '0;
            end
            if (sof) begin
               line_cnt <= '0;
            end else if (line_done) begin
               if (line_cnt == LINE_W'(LINES - 1)) begin
                  line_cnt <= '0;
               end else begin
                  line_cnt <= line_cnt + 1'b1;
               end
            end
         end
      end
   end

   // Pixels enter at the top and move down, pixel 0 ends in position 0.
   always_ff @(posedge clk) begin
      if (clk_enable && cap_active) begin
         line_reg <= next_line;
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         data_out <= '0;
      end else if (line_done) begin
         data_out <= next_line;
      end
   end

endmodule

`default_nettype wire

/* hdl/driver_formatter.sv */
`default_nettype none

module driver_formatter #(
   parameter int LINE_PIXELS = panel_pkg::DEF_LINE_PIXELS
) (
   input  wire panel_pkg::pixel_t [LINE_PIXELS-1:0]          line_in,
   output logic [LINE_PIXELS*3*panel_pkg::CHANNEL_W-1:0]     data_out
);

   localparam int CW = panel_pkg::CHANNEL_W;

   // Colour value moved up one bit, the driver ignores the low bit.
   function automatic logic [CW-1:0] chan_word(input logic [panel_pkg::COLOR_W-1:0] c);
      chan_word = CW'({c, 1'b0});
   endfunction

   // Three words per pixel in blue, green, red order, pixel 0 at the bottom.
   always_comb begin
      data_out = '0;
      for (int k = 0; k < LINE_PIXELS; k++) begin
         data_out[(3*k+0)*CW +: CW] = chan_word(line_in[k].blue);
         data_out[(3*k+1)*CW +: CW] = chan_word(line_in[k].green);
         data_out[(3*k+2)*CW +: CW] = chan_word(line_in[k].red);
      end
   end

endmodule

`default_nettype wire

/* hdl/panel_bank.sv */
`default_nettype none

module panel_bank #(
   parameter int NUM_BLOCKS  = panel_pkg::DEF_NUM_BLOCKS,
   parameter int NUM_SLICES  = panel_pkg::DEF_NUM_SLICES,
   parameter int RAM_DEPTH   = panel_pkg::DEF_RAM_DEPTH,
   parameter int LINE_PIXELS = panel_pkg::DEF_LINE_PIXELS
) (
   input  wire                                                    clk,
   input  wire                                                    nrst,
   input  wire                                                    clk_enable,
   pixel_wr_if.sink                                               wr,
   input  wire [panel_pkg::SLICE_CNT_W-1:0]                       wslice_cnt,
   input  wire [panel_pkg::SLICE_CNT_W-1:0]                       rslice_cnt,
   input  wire                                                    eoc,
   input  wire                                                    sof,
   output logic [NUM_BLOCKS*LINE_PIXELS*3*panel_pkg::CHANNEL_W-1:0] lines,
   output logic                                                   driver_sof,
   output logic                                                   line_valid
);

   localparam int CNT_W     = panel_pkg::SLICE_CNT_W;
   localparam int OFFSET_W  = $clog2(panel_pkg::SLICE_STEP);
   localparam int BLOCK_W   = $clog2(NUM_BLOCKS);
   localparam int ADDR_W    = $clog2(RAM_DEPTH);
   localparam int LINE_BITS = LINE_PIXELS * 3 * panel_pkg::CHANNEL_W;

   logic [OFFSET_W-1:0] offset;
   logic                end_of_write;
   logic                end_of_read;
   logic [CNT_W-1:0]    wdiff;
   logic [CNT_W-1:0]    wslice;
   logic [CNT_W-1:0]    rslice;
   logic                wslice_aligned;
   logic                wslice_ok;

   logic [NUM_BLOCKS-1:0] blk_sof;
   logic [NUM_BLOCKS-1:0] blk_valid;

   // The offset moves the write slice by one counter step per frame.
   assign wdiff          = wslice_cnt - CNT_W'(offset);
   assign wslice         = CNT_W'(wdiff / panel_pkg::SLICE_STEP);
   assign wslice_aligned = (wdiff % panel_pkg::SLICE_STEP) == 0;
   assign wslice_ok      = wslice_aligned && (wslice < CNT_W'(NUM_SLICES));
   assign rslice         = CNT_W'(rslice_cnt / panel_pkg::SLICE_STEP);

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         offset       <= '0;
         end_of_write <= 1'b0;
         end_of_read  <= 1'b0;
      end else begin
         if (wslice_aligned && (wslice == CNT_W'(NUM_SLICES))) begin
            end_of_write <= 1'b1;
         end
         if (rslice == CNT_W'(NUM_SLICES)) begin
            end_of_read <= 1'b1;
         end
         // Clearing wins over setting in the same cycle.
         if (end_of_write && end_of_read) begin
            end_of_write <= 1'b0;
            end_of_read  <= 1'b0;
            offset       <= offset + 1'b1;
         end
      end
   end

   for (genvar b = 0; b < NUM_BLOCKS; b++) begin : g_block
      panel_pkg::pixel_t                   ram_q [NUM_SLICES];
      panel_pkg::pixel_t                   fb_data;
      panel_pkg::pixel_t [LINE_PIXELS-1:0] fb_line;
      logic [ADDR_W-1:0]                   fb_addr;

      for (genvar s = 0; s < NUM_SLICES; s++) begin : g_slice
         logic ram_wen;

         assign ram_wen = wr.wen && (wr.block == BLOCK_W'(b)) && wslice_ok
                          && (wslice == CNT_W'(s));

         pixel_ram #(
            .RAM_DEPTH (RAM_DEPTH)
         ) u_pixel_ram (
            .clk   (clk),
            .wen   (ram_wen),
            .waddr (wr.addr),
            .wdata (wr.data),
            .raddr (fb_addr),
            .rdata (ram_q[s])
         );
      end

      // A read index past the last slice reads as black.
      always_comb begin
         fb_data = '0;
         for (int s = 0; s < NUM_SLICES; s++) begin
            if (rslice == CNT_W'(s)) begin
               fb_data = ram_q[s];
            end
         end
      end

      line_framebuffer #(
         .RAM_DEPTH   (RAM_DEPTH),
         .LINE_PIXELS (LINE_PIXELS)
      ) u_line_framebuffer (
         .clk        (clk),
         .nrst       (nrst),
         .clk_enable (clk_enable),
         .sof        (sof),
         .eoc        (eoc),
         .ram_addr   (fb_addr),
         .ram_data   (fb_data),
         .data_out   (fb_line),
         .driver_sof (blk_sof[b]),
         .line_valid (blk_valid[b])
      );

      driver_formatter #(
         .LINE_PIXELS (LINE_PIXELS)
      ) u_driver_formatter (
         .line_in  (fb_line),
         .data_out (lines[b*LINE_BITS +: LINE_BITS])
      );
   end

   // All framebuffers run in lock step, block 0 speaks for the bank.
   assign driver_sof = blk_sof[0];
   assign line_valid = blk_valid[0];

endmodule

`default_nettype wire

/* hdl/display_top.sv */
`default_nettype none

module display_top #(
   parameter int NUM_BLOCKS  = panel_pkg::DEF_NUM_BLOCKS,
   parameter int NUM_SLICES  = panel_pkg::DEF_NUM_SLICES,
   parameter int RAM_DEPTH   = panel_pkg::DEF_RAM_DEPTH,
   parameter int LINE_PIXELS = panel_pkg::DEF_LINE_PIXELS
) (
   input  wire                                                    clk,
   input  wire                                                    nrst,
   input  wire                                                    clk_enable,
   input  wire [$clog2(NUM_BLOCKS)-1:0]                           block_number,
   input  wire [$clog2(RAM_DEPTH)-1:0]                            pixel_number,
   input  wire [panel_pkg::PIXEL_W-1:0]                           pixel_data,
   input  wire                                                    write_enable,
   input  wire [panel_pkg::SLICE_CNT_W-1:0]                       wslice_cnt,
   input  wire [panel_pkg::SLICE_CNT_W-1:0]                       rslice_cnt,
   input  wire                                                    eoc,
   input  wire                                                    sof,
   output logic [NUM_BLOCKS*LINE_PIXELS*3*panel_pkg::CHANNEL_W-1:0] lines,
   output logic                                                   driver_sof,
   output logic                                                   line_valid
);

   pixel_wr_if #(
      .NUM_BLOCKS (NUM_BLOCKS),
      .RAM_DEPTH  (RAM_DEPTH)
   ) wr_bus ();

   // The pixel source writes one pixel per cycle with no back-pressure.
   assign wr_bus.block = block_number;
   assign wr_bus.addr  = pixel_number;
   assign wr_bus.data  = pixel_data;
   assign wr_bus.wen   = write_enable;

   panel_bank #(
      .NUM_BLOCKS  (NUM_BLOCKS),
      .NUM_SLICES  (NUM_SLICES),
      .RAM_DEPTH   (RAM_DEPTH),
      .LINE_PIXELS (LINE_PIXELS)
   ) u_panel_bank (
      .clk        (clk),
      .nrst       (nrst),
      .clk_enable (clk_enable),
      .wr         (wr_bus),
      .wslice_cnt (wslice_cnt),
      .rslice_cnt (rslice_cnt),
      .eoc        (eoc),
      .sof        (sof),
      .lines      (lines),
      .driver_sof (driver_sof),
      .line_valid (line_valid)
   );

endmodule

`default_nettype wire

/* tests/panel_checker.sv */
`default_nettype none

module panel_checker (
   input wire       clk,
   input wire       nrst,
   input wire       clk_enable,
   input wire       sof,
   input wire       driver_sof,
   input wire       line_valid,
   input wire       end_of_write,
   input wire       end_of_read,
   input wire [4:0] offset
);

   int fail_count = 0;

   a_valid_pulse : assert property (@(posedge clk) disable iff (!nrst)
      line_valid |=> !line_valid)
      else begin
         fail_count++;
         $error("line_valid stayed high for more than one cycle");
      end

   a_sof_follows : assert property (@(posedge clk) disable iff (!nrst)
      (clk_enable && sof) |=> driver_sof)
      else begin
         fail_count++;
         $error("driver_sof missing after an enabled SOF");
      end

   a_sof_source : assert property (@(posedge clk) disable iff (!nrst)
      driver_sof |-> $past(clk_enable && sof))
      else begin
         fail_count++;
         $error("driver_sof without an enabled SOF the cycle before");
      end

   // The offset steps by one, wrapping at 32, right after both flags are up.
   a_offset_step : assert property (@(posedge clk) disable iff (!nrst)
      (end_of_write && end_of_read) |=> (offset == $past(offset) + 5'd1))
      else begin
         fail_count++;
         $error("offset did not step after both end flags were set");
      end

   a_offset_hold : assert property (@(posedge clk) disable iff (!nrst)
      (offset != $past(offset)) |-> $past(end_of_write && end_of_read))
      else begin
         fail_count++;
         $error("offset changed without both end flags set");
      end

endmodule

bind panel_bank panel_checker u_panel_checker (
   .clk          (clk),
   .nrst         (nrst),
   .clk_enable   (clk_enable),
   .sof          (sof),
   .driver_sof   (driver_sof),
   .line_valid   (line_valid),
   .end_of_write (end_of_write),
   .end_of_read  (end_of_read),
   .offset       (offset)
);

`default_nettype wire

/* tests/display_top_tb.sv */
`default_nettype none

module display_top_tb;

   localparam int NUM_BLOCKS  = panel_pkg::DEF_NUM_BLOCKS;
   localparam int NUM_SLICES  = panel_pkg::DEF_NUM_SLICES;
   localparam int RAM_DEPTH   = panel_pkg::DEF_RAM_DEPTH;
   localparam int LINE_PIXELS = panel_pkg::DEF_LINE_PIXELS;
   localparam int STEP        = panel_pkg::SLICE_STEP;
   localparam int CW          = panel_pkg::CHANNEL_W;
   localparam int BLOCK_W     = $clog2(NUM_BLOCKS);
   localparam int ADDR_W      = $clog2(RAM_DEPTH);
   localparam int LINES       = RAM_DEPTH / LINE_PIXELS;
   localparam int LINES_W     = NUM_BLOCKS * LINE_PIXELS * 3 * CW;
   localparam int FILL_CYCLES = NUM_BLOCKS * NUM_SLICES * RAM_DEPTH;

   typedef struct {
      byte kind;
      int  a;
      int  b;
      int  c;
      int  d;
      int  e;
   } case_rec_t;

   logic                            clk;
   logic                            nrst;
   logic                            clk_enable;
   logic [$clog2(NUM_BLOCKS)-1:0]   block_number;
   logic [$clog2(RAM_DEPTH)-1:0]    pixel_number;
   logic [23:0]                     pixel_data;
   logic                            write_enable;
   logic [7:0]                      wslice_cnt;
   logic [7:0]                      rslice_cnt;
   logic                            eoc;
   logic                            sof;
   logic [LINES_W-1:0]              lines;
   logic                            driver_sof;
   logic                            line_valid;

   logic [23:0]        ref_mem [NUM_BLOCKS][NUM_SLICES][RAM_DEPTH];
   int                 m_offset;
   logic               m_eow;
   logic               m_eor;
   int                 m_line;
   logic [LINES_W-1:0] held;
   case_rec_t          recs [$];
   int                 errors;
   int                 cycles;
   int                 cycle_limit;

   display_top #(
      .NUM_BLOCKS  (NUM_BLOCKS),
      .NUM_SLICES  (NUM_SLICES),
      .RAM_DEPTH   (RAM_DEPTH),
      .LINE_PIXELS (LINE_PIXELS)
   ) u_display_top (
      .clk          (clk),
      .nrst         (nrst),
      .clk_enable   (clk_enable),
      .block_number (block_number),
      .pixel_number (pixel_number),
      .pixel_data   (pixel_data),
      .write_enable (write_enable),
      .wslice_cnt   (wslice_cnt),
      .rslice_cnt   (rslice_cnt),
      .eoc          (eoc),
      .sof          (sof),
      .lines        (lines),
      .driver_sof   (driver_sof),
      .line_valid   (line_valid)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Timeout: the run went past %0d cycles", cycle_limit);
         $display("Finished with errors");
         $finish;
      end
   end

   // Reference of the slice rules, it watches the write port and both counters.
   always @(posedge clk or negedge nrst) begin : slice_model
      logic [7:0] wd;
      int         ws;
      if (!nrst) begin
         m_offset <= 0;
         m_eow    <= 1'b0;
         m_eor    <= 1'b0;
      end else begin
         wd = wslice_cnt - 8'(m_offset);
         ws = int'(wd) / STEP;
         if (write_enable && (int'(wd) % STEP == 0) && ws < NUM_SLICES) begin
            ref_mem[block_number][ws][pixel_number] <= pixel_data;
         end
         if (m_eow && m_eor) begin
            m_eow    <= 1'b0;
            m_eor    <= 1'b0;
            m_offset <= (m_offset + 1) % 32;
         end else begin
            m_eow <= m_eow || ((int'(wd) % STEP == 0) && ws == NUM_SLICES);
            m_eor <= m_eor || (int'(rslice_cnt) / STEP == NUM_SLICES);
         end
      end
   end

   function automatic logic [23:0] fill_pixel(input int b, input int s, input int a);
      return {8'(s * 32 + a * 2 + 1), 8'(b * 80 + a * 5), 8'((s * 29) ^ (a * 13) ^ b)};
   endfunction

   function automatic logic [LINES_W-1:0] expected_lines(input int rs, input int line);
      logic [LINES_W-1:0] v;
      logic [23:0]        px;
      int                 base;
      v = '0;
      for (int b = 0; b < NUM_BLOCKS; b++) begin
         for (int k = 0; k < LINE_PIXELS; k++) begin
            px = 24'h0;
            if (rs < NUM_SLICES) begin
               px = ref_mem[b][rs][line * LINE_PIXELS + k];
            end
            // Blue, green, red, each colour byte moved up one bit.
            base = (b * LINE_PIXELS + k) * 3 * CW;
            v[base +: CW]          = {px[7:0], 1'b0};
            v[base + CW +: CW]     = {px[15:8], 1'b0};
            v[base + 2 * CW +: CW] = {px[23:16], 1'b0};
         end
      end
      return v;
   endfunction

   task automatic count_mismatch(input string msg);
      errors++;
      $display("ERR @%0t: %s", $time, msg);
   endtask

   task automatic check_lines(input logic [LINES_W-1:0] exp, input string what);
      int w;
      w = 0;
      while (w < LINES_W / CW && lines[w * CW +: CW] === exp[w * CW +: CW]) begin
         w++;
      end
      assert (lines === exp) else begin
         count_mismatch($sformatf("%s word %0d got %03h expected %03h", what, w,
                                  lines[w * CW +: CW], exp[w * CW +: CW]));
      end
   endtask

   task automatic load_cases(output int ok);
      int        fd;
      string     text;
      case_rec_t r;
      fd = $fopen("tests/panel_cases.txt", "r");
      ok = (fd != 0) ? 1 : 0;
      if (fd != 0) begin
         while ($fgets(text, fd) > 0) begin
            r = '{kind: text.getc(0), a: 0, b: 0, c: 0, d: 0, e: 0};
            void'($sscanf(text.substr(1, text.len() - 1), "%d %d %h %d %d",
                          r.a, r.b, r.c, r.d, r.e));
            if (r.kind inside {"w", "r", "s", "c"}) begin
               recs.push_back(r);
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic idle_gap();
      int n;
      n = $urandom % 3;
      repeat (n) begin
         clk_enable = 1'b0;
         @(negedge clk);
         assert (lines === held) else count_mismatch("lines changed while clk_enable was low");
      end
      clk_enable = 1'b1;
   endtask

   task automatic write_pixel(input int blk, input int addr, input int px, input int cnt,
                              input int wen);
      block_number = BLOCK_W'(blk);
      pixel_number = ADDR_W'(addr);
      pixel_data   = 24'(px);
      wslice_cnt   = 8'(cnt);
      write_enable = (wen != 0);
      @(negedge clk);
      write_enable = 1'b0;
      wslice_cnt   = '0;
   endtask

   task automatic pulse_counters(input int wcnt, input int rcnt);
      wslice_cnt = 8'(wcnt);
      rslice_cnt = 8'(rcnt);
      @(negedge clk);
      wslice_cnt = '0;
      rslice_cnt = '0;
   endtask

   task automatic pulse_sof();
      sof = 1'b1;
      @(negedge clk);
      sof = 1'b0;
      assert (driver_sof === 1'b1) else count_mismatch("driver_sof did not follow SOF");
      m_line = 0;
   endtask

   // Enabled clock edges are counted from the EOC edge up to line_valid.
   task automatic read_line(input int rcnt, input int gaps);
      int                 n_en;
      logic [LINES_W-1:0] exp;
      rslice_cnt = 8'(rcnt);
      eoc        = 1'b1;
      @(negedge clk);
      eoc  = 1'b0;
      n_en = 1;
      while (!line_valid) begin
         assert (lines === held) else count_mismatch("lines changed before line_valid");
         clk_enable = (gaps == 0) || ($urandom % 3 != 0);
         @(negedge clk);
         if (clk_enable) begin
            n_en++;
         end
      end
      assert (n_en == LINE_PIXELS + 2) else begin
         count_mismatch($sformatf("line_valid after %0d enabled cycles, expected %0d",
                                  n_en, LINE_PIXELS + 2));
      end
      exp = expected_lines(rcnt / STEP, m_line);
      check_lines(exp, $sformatf("line %0d slice %0d", m_line, rcnt / STEP));
      held       = exp;
      m_line     = (m_line + 1) % LINES;
      clk_enable = 1'b1;
      rslice_cnt = '0;
   endtask

   initial begin : stimulus
      int ok;
      clk          = 1'b0;
      nrst         = 1'b0;
      clk_enable   = 1'b1;
      block_number = '0;
      pixel_number = '0;
      pixel_data   = '0;
      write_enable = 1'b0;
      wslice_cnt   = '0;
      rslice_cnt   = '0;
      eoc          = 1'b0;
      sof          = 1'b0;
      held         = '0;
      m_line       = 0;
      errors       = 0;
      cycles       = 0;
      cycle_limit  = 0;
      void'($urandom(28115));
      load_cases(ok);
      if (ok == 0) begin
         $display("Could not open the cases file tests/panel_cases.txt");
         $display("Finished with errors");
         $finish;
      end else begin
         cycle_limit = 40 * recs.size() + 200 + FILL_CYCLES;
         repeat (3) @(negedge clk);
         nrst = 1'b1;
         check_lines('0, "after reset");
         // RAM contents are undefined at power-up, so every slice gets a known pattern.
         for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int s = 0; s < NUM_SLICES; s++) begin
               for (int a = 0; a < RAM_DEPTH; a++) begin
                  write_pixel(b, a, int'(fill_pixel(b, s, a)), s * STEP, 1);
               end
            end
         end
         foreach (recs[i]) begin
            idle_gap();
            case (recs[i].kind)
               "w": write_pixel(recs[i].a, recs[i].b, recs[i].c, recs[i].d, recs[i].e);
               "r": read_line(recs[i].a, recs[i].b);
               "s": pulse_sof();
               default: pulse_counters(recs[i].a, recs[i].b);
            endcase
         end
         repeat (4) @(negedge clk);
         errors += u_display_top.u_panel_bank.u_panel_checker.fail_count;
         $display("Errors counted: %0d over %0d records", errors, recs.size());
         if (errors == 0) begin
            $display("Finished with no errors");
         end else begin
            $display("Finished with errors");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

/* tests/panel_cases.txt */
# w block addr pixel_hex wslice_cnt write_enable | r rslice_cnt clk_enable_gaps
# s (SOF pulse) | c wslice_cnt rslice_cnt (counters held for one cycle)
s
w 0 0 a1b2c3 0 1
w 0 1 102030 0 1
w 1 2 ffee01 0 1
w 2 3 00ff80 0 1
r 0 0
w 0 4 123456 0 1
w 1 5 abcdef 16 1
w 2 6 777777 0 0
r 0 0
r 32 1
r 64 0
r 0 0
s
r 224 1
c 224 0
c 0 0
w 0 0 c0ffee 1 1
w 1 0 0badf0 32 1
w 2 4 5a5a5a 33 1
s
r 0 0
r 32 1
c 225 224
c 0 0
w 1 8 13579b 2 1
r 0 1

/* sources.f */
hdl/panel_pkg.sv
hdl/pixel_wr_if.sv
hdl/pixel_ram.sv
hdl/line_framebuffer.sv
hdl/driver_formatter.sv
hdl/panel_bank.sv
hdl/display_top.sv
tests/panel_checker.sv
tests/display_top_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TB_TOP     ?= display_top_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

SHELL := /bin/bash

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	set -o pipefail; ./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation reported failures, see $(LOG)"; exit 1; \
	fi
	@grep -q "Finished with no errors" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
